// File: source/DataPkg.sv
package DataPkg;

    // data words and addresses share one width
    typedef logic [31:0] word_t;

    // architectural register index, x0..x31
    typedef logic [4:0] regIdx_t;

    // one bit per byte lane of a word
    typedef logic [3:0] byteEn_t;

endpackage

// File: source/DecodePkg.sv
package DecodePkg;

    // instruction fields
    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;

    // major opcodes
    localparam opcode_t OpArtLog = 7'b0110011;
    localparam opcode_t OpArtImm = 7'b0010011;
    localparam opcode_t OpLoad   = 7'b0000011;
    localparam opcode_t OpStore  = 7'b0100011;
    localparam opcode_t OpBranch = 7'b1100011;
    localparam opcode_t OpJalr   = 7'b1100111;
    localparam opcode_t OpJal    = 7'b1101111;
    localparam opcode_t OpLui    = 7'b0110111;
    localparam opcode_t OpAuipc  = 7'b0010111;

    localparam func3_t F3Add  = 3'b000;   // also sub
    localparam func3_t F3Sll  = 3'b001;
    localparam func3_t F3Slt  = 3'b010;
    localparam func3_t F3Sltu = 3'b011;
    localparam func3_t F3Xor  = 3'b100;
    localparam func3_t F3Srl  = 3'b101;   // also sra
    localparam func3_t F3Or   = 3'b110;
    localparam func3_t F3And  = 3'b111;

    localparam func3_t F3Lb  = 3'b000;
    localparam func3_t F3Lh  = 3'b001;
    localparam func3_t F3Lw  = 3'b010;
    localparam func3_t F3Lbu = 3'b100;
    localparam func3_t F3Lhu = 3'b101;

    localparam func3_t F3Sb = 3'b000;
    localparam func3_t F3Sh = 3'b001;
    localparam func3_t F3Sw = 3'b010;

    localparam func3_t F3Beq  = 3'b000;
    localparam func3_t F3Bne  = 3'b001;
    localparam func3_t F3Blt  = 3'b100;
    localparam func3_t F3Bge  = 3'b101;
    localparam func3_t F3Bltu = 3'b110;
    localparam func3_t F3Bgeu = 3'b111;

    // selects sub and sra
    localparam func7_t Func7Alt = 7'h20;

    typedef enum logic [3:0] {
        Add, Sub, Sll, Slt, Sltu, Xor, Srl, Sra, Or, And
    } aluOp_t;

    typedef enum logic [2:0] {
        Nop, Eq, Ne, Lt, Ge, Ltu, Geu, Jmp
    } bruOp_t;

    typedef enum logic [3:0] {
        None, Lb, Lh, Lw, Lbu, Lhu, Sb, Sh, Sw
    } ldst_t;

endpackage

// File: source/CtrlIf.sv
interface CtrlIf import DecodePkg::*; ();

    aluOp_t aluOp;
    bruOp_t bruOp;
    logic   aluSrc;     // 1: imm, 0: rs2
    logic   memWrite;
    logic   memRead;
    logic   regWrite;
    logic   memToReg;   // load data to rd
    logic   jal;        // jal or jalr
    logic   branch;
    logic   predict;    // static taken prediction
    logic   ujtype;     // u or j format
    ldst_t  ldst;

    modport decoder (
        output aluOp, bruOp, aluSrc, memWrite, memRead, regWrite,
               memToReg, jal, branch, predict, ujtype, ldst
    );

    modport exec (
        input aluOp, bruOp, aluSrc, memWrite, memRead, regWrite,
              memToReg, jal, branch, predict, ujtype, ldst
    );

endinterface

// File: source/Control.sv
module Control import DecodePkg::*; (
    input  inst_t inst,
    CtrlIf.decoder ctrl
);

    opcode_t opcode;
    func3_t  func3;
    func7_t  func7;

    assign opcode = inst[6:0];
    assign func3  = inst[14:12];
    assign func7  = inst[31:25];

    assign ctrl.jal = (opcode == OpJalr) || (opcode == OpJal);

    always_comb begin : ctrlGen
        // everything inactive unless the opcode says otherwise
        ctrl.aluOp    = Add;
        ctrl.bruOp    = Nop;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.predict  = 1'b0;
        ctrl.ujtype   = 1'b0;
        ctrl.ldst     = None;

        unique case (opcode)
            OpArtLog, OpArtImm: begin
                unique case (func3)
                    F3Add:  ctrl.aluOp = (opcode == OpArtLog && func7 == Func7Alt) ? Sub : Add;
                    F3Sll:  ctrl.aluOp = Sll;
                    F3Slt:  ctrl.aluOp = Slt;
                    F3Sltu: ctrl.aluOp = Sltu;
                    F3Xor:  ctrl.aluOp = Xor;
                    F3Srl:  ctrl.aluOp = (func7 == Func7Alt) ? Sra : Srl;
                    F3Or:   ctrl.aluOp = Or;
                    F3And:  ctrl.aluOp = And;
                endcase
                ctrl.aluSrc   = (opcode == OpArtImm);
                ctrl.regWrite = 1'b1;
            end
            OpLoad: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                unique case (func3)
                    F3Lb:    ctrl.ldst = Lb;
                    F3Lh:    ctrl.ldst = Lh;
                    F3Lw:    ctrl.ldst = Lw;
                    F3Lbu:   ctrl.ldst = Lbu;
                    F3Lhu:   ctrl.ldst = Lhu;
                    default: ctrl.ldst = None;
                endcase
            end
            OpStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                unique case (func3)
                    F3Sb:    ctrl.ldst = Sb;
                    F3Sh:    ctrl.ldst = Sh;
                    F3Sw:    ctrl.ldst = Sw;
                    default: ctrl.ldst = None;
                endcase
            end
            OpBranch: begin
                unique case (func3)
                    F3Beq:   ctrl.bruOp = Eq;
                    F3Bne:   ctrl.bruOp = Ne;
                    F3Blt:   ctrl.bruOp = Lt;
                    F3Bge:   ctrl.bruOp = Ge;
                    F3Bltu:  ctrl.bruOp = Ltu;
                    F3Bgeu:  ctrl.bruOp = Geu;
                    default: ctrl.bruOp = Nop;
                endcase
                ctrl.branch  = 1'b1;
                ctrl.predict = 1'b1;    // always predicted taken
            end
            OpJalr: begin
                ctrl.bruOp    = Jmp;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
            end
            OpJal: begin
                ctrl.bruOp    = Jmp;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
                ctrl.ujtype   = 1'b1;
            end
            OpLui: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.ujtype   = 1'b1;
            end
            OpAuipc: begin
                // branch unit forms pc+imm, no redirect since jal is low
                ctrl.bruOp    = Jmp;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.branch   = 1'b1;
                ctrl.ujtype   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: source/ImmGen.sv
module ImmGen import DataPkg::*, DecodePkg::*; (
    input  inst_t inst,
    output word_t imm
);

    word_t immI, immS, immB, immU, immJ;

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        unique case (inst[6:0])
            OpArtImm, OpLoad, OpJalr: imm = immI;
            OpStore:                  imm = immS;
            OpBranch:                 imm = immB;
            OpLui, OpAuipc:           imm = immU;
            OpJal:                    imm = immJ;
            default:                  imm = '0;   // r-type has none
        endcase
    end

endmodule

// File: source/RegFile.sv
module RegFile import DataPkg::*; #(
    parameter int RegCount = 32
) (
    input  logic    clk,
    input  logic    rstN,
    input  regIdx_t rs1Addr,
    input  regIdx_t rs2Addr,
    output word_t   rs1Data,
    output word_t   rs2Data,
    input  logic    wrEn,
    input  regIdx_t wrAddr,
    input  word_t   wrData
);

    localparam int IdxBits = $clog2(RegCount);

    word_t regs [RegCount];

    // upper index bits dropped for rv32e
    assign rs1Data = regs[rs1Addr[IdxBits-1:0]];
    assign rs2Data = regs[rs2Addr[IdxBits-1:0]];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr[IdxBits-1:0] != '0) begin   // x0 stays zero
            regs[wrAddr[IdxBits-1:0]] <= wrData;
        end
    end

endmodule

// File: source/Alu.sv
module Alu import DataPkg::*, DecodePkg::*; (
    CtrlIf.exec   ctrl,
    input  word_t rs1Data,
    input  word_t rs2Data,
    input  word_t imm,
    output word_t result
);

    word_t      opB;
    logic [4:0] shamt;

    assign opB   = ctrl.aluSrc ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        unique case (ctrl.aluOp)
            Add:  result = rs1Data + opB;
            Sub:  result = rs1Data - opB;
            Sll:  result = rs1Data << shamt;
            Slt:  result = word_t'($signed(rs1Data) < $signed(opB));
            Sltu: result = word_t'(rs1Data < opB);
            Xor:  result = rs1Data ^ opB;
            Srl:  result = rs1Data >> shamt;
            Sra:  result = word_t'($signed(rs1Data) >>> shamt);
            Or:   result = rs1Data | opB;
            And:  result = rs1Data & opB;
            default: result = '0;
        endcase
    end

endmodule

// File: source/BranchUnit.sv
module BranchUnit import DataPkg::*, DecodePkg::*; (
    CtrlIf.exec   ctrl,
    input  word_t pc,
    input  word_t rs1Data,
    input  word_t rs2Data,
    input  word_t imm,
    output logic  redirect,
    output word_t redirectPc,
    output word_t pcRel,
    output word_t link
);

    logic  taken;
    logic  condBranch;
    word_t jalrTarget;
    word_t takenPc;

    always_comb begin
        unique case (ctrl.bruOp)
            Eq:      taken = (rs1Data == rs2Data);
            Ne:      taken = (rs1Data != rs2Data);
            Lt:      taken = ($signed(rs1Data) < $signed(rs2Data));
            Ge:      taken = ($signed(rs1Data) >= $signed(rs2Data));
            Ltu:     taken = (rs1Data < rs2Data);
            Geu:     taken = (rs1Data >= rs2Data);
            Jmp:     taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign pcRel      = pc + imm;
    assign link       = pc + 32'd4;
    assign jalrTarget = (rs1Data + imm) & ~32'd1;
    assign takenPc    = (ctrl.jal && !ctrl.ujtype) ? jalrTarget : pcRel;

    // auipc also carries Jmp but is not a conditional branch
    assign condBranch = ctrl.branch && !ctrl.jal && ctrl.bruOp != Jmp;

    assign redirect   = ctrl.jal || (condBranch && taken != ctrl.predict);
    assign redirectPc = taken ? takenPc : link;   // mispredicted taken falls through

endmodule

// File: source/MemAlign.sv
module MemAlign import DataPkg::*, DecodePkg::*; (
    CtrlIf.exec     ctrl,
    input  word_t   addr,
    input  word_t   rs2Data,
    input  word_t   memRdata,
    output byteEn_t byteEn,
    output word_t   memWdata,
    output word_t   loadData
);

    logic [1:0]  offset;
    logic [4:0]  laneShift;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    word_t       shifted;

    assign offset    = addr[1:0];
    assign laneShift = {offset, 3'b000};

    // store side, data moved up to its byte lane
    always_comb begin
        memWdata = rs2Data << laneShift;
        unique case (ctrl.ldst)
            Sb:      byteEn = byteEn_t'(4'b0001 << offset);
            Sh:      byteEn = offset[1] ? 4'b1100 : 4'b0011;
            Sw:      byteEn = 4'b1111;
            default: byteEn = 4'b0000;
        endcase
        if (!ctrl.memWrite) begin
            byteEn = 4'b0000;
        end
    end

    assign shifted  = memRdata >> laneShift;
    assign loadByte = shifted[7:0];
    assign loadHalf = offset[1] ? memRdata[31:16] : memRdata[15:0];

    always_comb begin
        unique case (ctrl.ldst)
            Lb:      loadData = {{24{loadByte[7]}}, loadByte};
            Lh:      loadData = {{16{loadHalf[15]}}, loadHalf};
            Lbu:     loadData = {24'b0, loadByte};
            Lhu:     loadData = {16'b0, loadHalf};
            default: loadData = memRdata;    // lw
        endcase
    end

endmodule

// File: source/DecodeExec.sv
module DecodeExec import DataPkg::*, DecodePkg::*; #(
    parameter int RegCount = 32
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    instValid,
    input  inst_t   inst,
    input  word_t   pc,
    output logic    memRead,
    output logic    memWrite,
    output word_t   memAddr,
    output byteEn_t memByteEn,
    output word_t   memWdata,
    input  word_t   memRdata,
    output logic    wbValid,
    output regIdx_t wbAddr,
    output word_t   wbData,
    output logic    redirect,
    output word_t   redirectPc
);

    regIdx_t rd;
    word_t   imm, rs1Data, rs2Data, aluResult;
    word_t   pcRel, link, loadData, wbSel, nextPc;
    logic    regWrEn;
    logic    takeRedirect;

    CtrlIf ctrlBus ();

    assign rd = inst[11:7];

    Control i_Control (.inst(inst), .ctrl(ctrlBus.decoder));

    ImmGen i_ImmGen (.inst(inst), .imm(imm));

    RegFile #(.RegCount(RegCount)) i_RegFile (
        .clk(clk), .rstN(rstN),
        .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wrEn(regWrEn), .wrAddr(rd), .wrData(wbSel)
    );

    Alu i_Alu (
        .ctrl(ctrlBus.exec), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .imm(imm), .result(aluResult)
    );

    BranchUnit i_BranchUnit (
        .ctrl(ctrlBus.exec), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .redirect(takeRedirect), .redirectPc(nextPc), .pcRel(pcRel), .link(link)
    );

    MemAlign i_MemAlign (
        .ctrl(ctrlBus.exec), .addr(aluResult), .rs2Data(rs2Data), .memRdata(memRdata),
        .byteEn(memByteEn), .memWdata(memWdata), .loadData(loadData)
    );

    assign memRead  = instValid & ctrlBus.memRead;
    assign memWrite = instValid & ctrlBus.memWrite;
    assign memAddr  = aluResult;    // rs1+imm for loads and stores
    assign regWrEn  = instValid & ctrlBus.regWrite;

    always_comb begin
        if (ctrlBus.jal)                           wbSel = link;
        else if (ctrlBus.ujtype && ctrlBus.branch) wbSel = pcRel;  // auipc
        else if (ctrlBus.ujtype)                   wbSel = imm;    // lui
        else if (ctrlBus.memToReg)                 wbSel = loadData;
        else                                       wbSel = aluResult;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid  <= 1'b0;
            redirect <= 1'b0;
        end else begin
            wbValid  <= regWrEn;
            redirect <= instValid & takeRedirect;
        end
    end

    always_ff @(posedge clk) begin
        if (instValid) begin
            wbAddr     <= rd;
            wbData     <= wbSel;
            redirectPc <= nextPc;
        end
    end

endmodule

// File: tb/ClockGen.sv
module ClockGen (
    output logic clk,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rstN <= 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// File: tb/decodeExec_properties.sv
module decodeExec_properties import DataPkg::*, DecodePkg::*; (
    input logic    clk,
    input logic    rstN,
    input logic    instValid,
    input inst_t   inst,
    input word_t   pc,
    input logic    memRead,
    input logic    memWrite,
    input word_t   memAddr,
    input byteEn_t memByteEn,
    input word_t   memWdata,
    input word_t   memRdata,
    input logic    wbValid,
    input regIdx_t wbAddr,
    input word_t   wbData,
    input logic    redirect,
    input word_t   redirectPc
);

    timeunit 1ns;
    timeprecision 1ns;

    int failCount = 0;

    word_t   shadow [32];   // register model, x0 never written
    opcode_t opc;
    func3_t  f3;
    regIdx_t rd;
    word_t   a, b, immI, immS, immU, immJ, addr, lane;
    logic    alt, taken;

    logic    expWr, expRedir, expLoad, expStore;
    word_t   expWb, expPc, expWdata, expMask;
    byteEn_t expBe;

    // expectations of the last strobe lined up with the registered outputs
    logic    validQ, expWrQ, expRedirQ;
    regIdx_t rdQ;
    word_t   expWbQ, expPcQ;

    function automatic word_t aluCalc(input func3_t f, input logic sub, input word_t x,
                                      input word_t y);
        case (f)
            3'b000:  return sub ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return word_t'($signed(x) < $signed(y));
            3'b011:  return word_t'(x < y);
            3'b100:  return x ^ y;
            3'b101:  return sub ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    always_comb begin
        opc   = inst[6:0];
        f3    = inst[14:12];
        rd    = inst[11:7];
        a     = shadow[inst[19:15]];
        b     = shadow[inst[24:20]];
        immI  = {{20{inst[31]}}, inst[31:20]};
        immS  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immU  = {inst[31:12], 12'b0};
        immJ  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        alt   = inst[31:25] == 7'h20 && (opc == OpArtLog || f3 == 3'b101);
        addr  = a + ((opc == OpStore) ? immS : immI);
        lane  = memRdata >> {addr[1:0], 3'b000};   // addressed byte or half at bit 0
        case (f3)
            3'b000:  taken = a == b;
            3'b001:  taken = a != b;
            3'b100:  taken = $signed(a) < $signed(b);
            3'b101:  taken = $signed(a) >= $signed(b);
            3'b110:  taken = a < b;
            default: taken = a >= b;
        endcase

        expWr    = 1'b0;
        expRedir = 1'b0;
        expLoad  = 1'b0;
        expStore = 1'b0;
        expWb    = '0;
        expPc    = '0;
        expBe    = '0;
        expWdata = '0;
        case (opc)
            OpArtLog: begin
                expWr = 1'b1;
                expWb = aluCalc(f3, alt, a, b);
            end
            OpArtImm: begin
                expWr = 1'b1;
                expWb = aluCalc(f3, alt, a, immI);
            end
            OpLui: begin
                expWr = 1'b1;
                expWb = immU;
            end
            OpAuipc: begin
                expWr = 1'b1;
                expWb = pc + immU;
            end
            OpJal, OpJalr: begin
                expWr    = 1'b1;
                expWb    = pc + 4;
                expRedir = 1'b1;
                expPc    = (opc == OpJal) ? pc + immJ : (a + immI) & ~32'd1;
            end
            OpBranch: begin
                expRedir = !taken;   // predicted taken, so only a fall-through redirects
                expPc    = pc + 4;
            end
            OpLoad: begin
                expWr   = 1'b1;
                expLoad = 1'b1;
                case (f3)
                    3'b000:  expWb = {{24{lane[7]}}, lane[7:0]};
                    3'b001:  expWb = {{16{lane[15]}}, lane[15:0]};
                    3'b100:  expWb = {24'b0, lane[7:0]};
                    3'b101:  expWb = {16'b0, lane[15:0]};
                    default: expWb = memRdata;
                endcase
            end
            OpStore: begin
                expStore = 1'b1;
                expBe    = (f3 == 3'b010) ? 4'b1111 :
                           (f3 == 3'b001) ? (4'b0011 << addr[1:0]) : (4'b0001 << addr[1:0]);
                expWdata = (f3 == 3'b010) ? b : (f3 == 3'b001) ? {2{b[15:0]}} : {4{b[7:0]}};
            end
            default: ;
        endcase
        expMask = {{8{expBe[3]}}, {8{expBe[2]}}, {8{expBe[1]}}, {8{expBe[0]}}};
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            validQ <= instValid;
            if (instValid && expWr && rd != 0) begin
                shadow[rd] <= expWb;
            end
        end
        expWrQ    <= expWr;
        expRedirQ <= expRedir;
        rdQ       <= rd;
        expWbQ    <= expWb;
        expPcQ    <= expPc;
    end

    checkReset: assert property (@(posedge clk) $rose(rstN) |-> !wbValid && !redirect)
        else begin
            failCount++;
            $error("wbValid or redirect is high right after reset");
        end

    checkWbValid: assert property (@(posedge clk) disable iff (!rstN)
        wbValid == (validQ && expWrQ))
        else begin
            failCount++;
            $error("error %0t wbValid got %b expected %b", $time, $sampled(wbValid),
                   $sampled(validQ && expWrQ));
        end

    checkWbAddr: assert property (@(posedge clk) disable iff (!rstN)
        validQ && expWrQ |-> wbAddr == rdQ)
        else begin
            failCount++;
            $error("error %0t wbAddr got %0d expected %0d", $time, $sampled(wbAddr),
                   $sampled(rdQ));
        end

    checkWbData: assert property (@(posedge clk) disable iff (!rstN)
        validQ && expWrQ |-> wbData == expWbQ)
        else begin
            failCount++;
            $error("error %0t wbData got %h expected %h", $time, $sampled(wbData),
                   $sampled(expWbQ));
        end

    checkRedirect: assert property (@(posedge clk) disable iff (!rstN)
        redirect == (validQ && expRedirQ))
        else begin
            failCount++;
            $error("error %0t redirect got %b expected %b", $time, $sampled(redirect),
                   $sampled(validQ && expRedirQ));
        end

    checkRedirectPc: assert property (@(posedge clk) disable iff (!rstN)
        validQ && expRedirQ |-> redirectPc == expPcQ)
        else begin
            failCount++;
            $error("error %0t redirectPc got %h expected %h", $time, $sampled(redirectPc),
                   $sampled(expPcQ));
        end

    checkMemRead: assert property (@(posedge clk) disable iff (!rstN)
        memRead == (instValid && expLoad))
        else begin
            failCount++;
            $error("error %0t memRead got %b expected %b", $time, $sampled(memRead),
                   $sampled(instValid && expLoad));
        end

    checkMemWrite: assert property (@(posedge clk) disable iff (!rstN)
        memWrite == (instValid && expStore))
        else begin
            failCount++;
            $error("error %0t memWrite got %b expected %b", $time, $sampled(memWrite),
                   $sampled(instValid && expStore));
        end

    checkMemAddr: assert property (@(posedge clk) disable iff (!rstN)
        instValid && (expLoad || expStore) |-> memAddr == addr)
        else begin
            failCount++;
            $error("error %0t memAddr got %h expected %h", $time, $sampled(memAddr),
                   $sampled(addr));
        end

    checkByteEn: assert property (@(posedge clk) disable iff (!rstN)
        instValid && expStore |-> memByteEn == expBe)
        else begin
            failCount++;
            $error("error %0t memByteEn got %b expected %b", $time, $sampled(memByteEn),
                   $sampled(expBe));
        end

    // only the enabled lanes carry data
    checkWdata: assert property (@(posedge clk) disable iff (!rstN)
        instValid && expStore |-> (memWdata & expMask) == (expWdata & expMask))
        else begin
            failCount++;
            $error("error %0t memWdata got %h expected %h", $time,
                   $sampled(memWdata & expMask), $sampled(expWdata & expMask));
        end

endmodule

// File: tb/DecodeExecTb.sv
module DecodeExecTb import DataPkg::*, DecodePkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    logic    clk, rstN, instValid;
    inst_t   inst;
    word_t   pc, memAddr, memWdata, memRdata, wbData, redirectPc;
    logic    memRead, memWrite, wbValid, redirect;
    byteEn_t memByteEn;
    regIdx_t wbAddr;

    word_t dataMem [64];
    word_t rngState;
    word_t nextPc;
    int    issued, timeouts;

    ClockGen i_ClockGen (.clk(clk), .rstN(rstN));

    DecodeExec #(.RegCount(32)) i_DecodeExec (.*);

    bind DecodeExec decodeExec_properties checks (.*);

    assign memRdata = dataMem[memAddr[7:2]];   // answers in the strobe cycle

    always @(posedge clk) begin
        if (memWrite) begin
            for (int k = 0; k < 4; k++) begin
                if (memByteEn[k]) begin
                    dataMem[memAddr[7:2]][8*k +: 8] <= memWdata[8*k +: 8];
                end
            end
        end
    end

    function automatic word_t nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic regIdx_t randReg();   // operands live in x1..x8
        return regIdx_t'(1 + nextRand() % 8);
    endfunction

    function automatic inst_t encR(input func7_t f7, input regIdx_t rs2, input regIdx_t rs1,
                                   input func3_t f3, input regIdx_t rd);
        return {f7, rs2, rs1, f3, rd, OpArtLog};
    endfunction

    function automatic inst_t encI(input logic [11:0] imm, input regIdx_t rs1, input func3_t f3,
                                   input regIdx_t rd, input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t encS(input logic [11:0] imm, input regIdx_t rs2, input regIdx_t rs1,
                                   input func3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OpStore};
    endfunction

    function automatic inst_t encB(input logic [12:0] imm, input regIdx_t rs2, input regIdx_t rs1,
                                   input func3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch};
    endfunction

    function automatic inst_t encU(input logic [19:0] imm, input regIdx_t rd, input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t encJ(input logic [20:0] imm, input regIdx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal};
    endfunction

    task automatic strobe(input inst_t i);
        @(posedge clk);
        instValid <= 1'b1;
        inst      <= i;
        pc        <= nextPc;
        nextPc    += 4;
        issued++;
    endtask

    // ends the strobes and waits for the writeback where one is due
    task automatic settle(input logic expectWb);
        int n;
        @(posedge clk);
        instValid <= 1'b0;
        if (expectWb) begin
            n = 0;
            @(negedge clk);
            while (!wbValid && n < 8) begin
                @(negedge clk);
                n++;
            end
            if (!wbValid) begin
                timeouts++;
                $display("timeout at %0t, no writeback for instruction %h", $time, inst);
            end
        end
    endtask

    task automatic issue(input inst_t i, input logic expectWb);
        strobe(i);
        settle(expectWb);
    endtask

    task automatic loadConst(input regIdx_t rd, input word_t v);
        issue(encU(v[31:12] + v[11], rd, OpLui), 1'b1);   // addi sign-extends the low part
        issue(encI(v[11:0], rd, F3Add, rd, OpArtImm), 1'b1);
    endtask

    initial begin : stimulus
        word_t  v;
        func3_t f3;
        regIdx_t rs1;
        int     guard;
        instValid <= 1'b0;
        inst      <= '0;
        pc        <= '0;
        rngState  = 32'd79;
        nextPc    = 32'h0000_1000;
        issued    = 0;
        timeouts  = 0;
        for (int i = 0; i < 64; i++) begin
            dataMem[i] <= (i * 32'h9e37_79b1) ^ 32'hc3a5_0f81;
        end

        guard = 0;
        while (rstN !== 1'b1 && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        if (rstN !== 1'b1) begin
            timeouts++;
            $display("timeout waiting for the reset to be released");
        end

        for (int r = 1; r <= 8; r++) begin
            loadConst(regIdx_t'(r), nextRand());
        end

        // second pass sets func7 for sub and sra
        for (int k = 0; k < 16; k++) begin
            f3 = func3_t'(k);
            issue(encR((k[3] && (f3 == F3Add || f3 == F3Srl)) ? Func7Alt : 7'h00,
                       randReg(), randReg(), f3, regIdx_t'(9 + k % 6)), 1'b1);
        end
        for (int k = 0; k < 16; k++) begin
            f3 = func3_t'(k);
            v  = nextRand();
            if (f3 == F3Sll || f3 == F3Srl) begin
                v[11:5] = (k[3] && f3 == F3Srl) ? Func7Alt : 7'h00;
            end
            issue(encI(v[11:0], randReg(), f3, regIdx_t'(9 + k % 6), OpArtImm), 1'b1);
        end

        issue(encI(12'h080, 0, F3Add, 20, OpArtImm), 1'b1);   // x20 is the memory base
        for (int off = 0; off < 4; off++) begin
            issue(encS(12'(off), randReg(), 20, F3Sb), 1'b0);
        end
        issue(encS(12'd4, randReg(), 20, F3Sh), 1'b0);
        issue(encS(12'd6, randReg(), 20, F3Sh), 1'b0);
        issue(encS(12'd8, randReg(), 20, F3Sw), 1'b0);
        for (int off = 0; off < 12; off++) begin
            issue(encI(12'(off), 20, F3Lb, 21, OpLoad), 1'b1);
            issue(encI(12'(off), 20, F3Lbu, 21, OpLoad), 1'b1);
            if (off % 2 == 0) begin
                issue(encI(12'(off), 20, F3Lh, 21, OpLoad), 1'b1);
                issue(encI(12'(off), 20, F3Lhu, 21, OpLoad), 1'b1);
            end
            if (off % 4 == 0) begin
                issue(encI(12'(off), 20, F3Lw, 21, OpLoad), 1'b1);
            end
        end
        issue(encI(12'hffc, 20, F3Lw, 21, OpLoad), 1'b1);   // untouched fill word

        // first six compare a register with itself
        for (int k = 0; k < 18; k++) begin
            f3  = func3_t'((k % 6 < 2) ? k % 6 : k % 6 + 2);   // skips 010 and 011
            rs1 = randReg();
            v   = nextRand();
            issue(encB({v[12:1], 1'b0}, (k < 6) ? rs1 : randReg(), rs1, f3), 1'b0);
        end

        for (int k = 0; k < 4; k++) begin
            v = nextRand();
            issue(encJ({v[20:1], 1'b0}, 10), 1'b1);
            issue(encI(v[11:0], randReg(), 3'b000, 11, OpJalr), 1'b1);
            issue(encU(v[31:12], 12, OpAuipc), 1'b1);
            issue(encU(v[19:0], 13, OpLui), 1'b1);
        end

        issue(encI(12'h07b, 1, F3Add, 0, OpArtImm), 1'b1);   // write to x0 is dropped
        issue(encR(7'h00, 2, 0, F3Or, 14), 1'b1);
        issue(encR(7'h00, 0, 0, F3Add, 15), 1'b1);

        // dependent chain strobed back to back
        strobe(encI(12'h005, 0, F3Add, 16, OpArtImm));
        strobe(encI(12'h007, 16, F3Add, 16, OpArtImm));
        strobe(encR(7'h00, 16, 16, F3Add, 17));
        settle(1'b1);

        repeat (2) @(posedge clk);
        $display("instructions %0d, assertion failures %0d, timeouts %0d",
                 issued, i_DecodeExec.checks.failCount, timeouts);
        if (i_DecodeExec.checks.failCount == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/DataPkg.sv
source/DecodePkg.sv
source/CtrlIf.sv
source/Control.sv
source/ImmGen.sv
source/RegFile.sv
source/Alu.sv
source/BranchUnit.sv
source/MemAlign.sv
source/DecodeExec.sv
tb/ClockGen.sv
tb/decodeExec_properties.sv
tb/DecodeExecTb.sv
